// File: Bender.yml
package:
  name: gaussian_blur

export_include_dirs:
  - include

sources:
  - verilog/blur_pkg.sv
  - verilog/pixel_fifo.sv
  - verilog/blur_position.sv
  - verilog/blur_control.sv
  - verilog/blur_window.sv
  - verilog/blur_top.sv
  - target: test
    files:
      - testbench/blur_tb.sv

// File: include/blur_cfg.svh
// Image geometry, FIFO sizing and kernel divisor for the Gaussian blur engine
`ifndef BLUR_CFG_SVH
`define BLUR_CFG_SVH

// Pixels per image line, at least 5
`define BLUR_WIDTH 8

// Lines per frame, at least 3
`define BLUR_HEIGHT 6

// Entries in each pixel FIFO
// Must be a power of two for the wrap-bit pointers
`define BLUR_FIFO_DEPTH 16

// Sum of all kernel weights, used as a fixed denominator
`define BLUR_DIVISOR 159

`endif

// File: list.f
+incdir+include
verilog/blur_pkg.sv
verilog/pixel_fifo.sv
verilog/blur_position.sv
verilog/blur_control.sv
verilog/blur_window.sv
verilog/blur_top.sv
testbench/blur_tb.sv

// File: testbench/blur_tb.sv
// Directed testbench for the Gaussian blur top level with a software reference model
`timescale 1ns/1ps
`default_nettype none
`include "blur_cfg.svh"

module blur_tb
    import blur_pkg::*;
;

    localparam int W = `BLUR_WIDTH;
    localparam int H = `BLUR_HEIGHT;
    localparam int PIXELS = W * H;
    // Cycles any single wait may take
    localparam int WAIT_LIMIT = 2000;

    logic   clock;
    logic   reset;
    logic   in_wr_en;
    pixel_t in_din;
    logic   in_full;
    logic   out_rd_en;
    logic   out_empty;
    pixel_t out_dout;

    // Pixels still to write, expected outputs, outputs seen
    pixel_t in_q [$];
    pixel_t exp_q [$];
    pixel_t got_q [$];
    // Frame under construction for the model
    pixel_t frame_buf [PIXELS];
    int unsigned seed_val;

    blur_top dut_i (
        .clock(clock),
        .reset(reset),
        .in_wr_en(in_wr_en),
        .in_din(in_din),
        .in_full(in_full),
        .out_rd_en(out_rd_en),
        .out_empty(out_empty),
        .out_dout(out_dout)
    );

    always #50 clock = ~clock;

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        blur_state_t st;
        st = dut_i.blur_control_i.state;
        $display("Timed out waiting for %s, engine state %s", what, st.name());
        $display("Test FAILED");
        $fatal(1, "wait expired");
    endtask

    // Reference blur over in-image taps with the fixed divisor
    function automatic int blur_model(input int r, input int c);
        int sum;
        int tr;
        int tc;
        sum = 0;
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                tr = r + i - 2;
                tc = c + j - 2;
                if (tr >= 0 && tr < H && tc >= 0 && tc < W) begin
                    sum += int'(frame_buf[tr * W + tc]) * int'(blur_kernel[i][j]);
                end
            end
        end
        return sum / `BLUR_DIVISOR;
    endfunction

    // Constant frame when value >= 0, random otherwise
    task automatic make_frame(input int value);
        for (int p = 0; p < PIXELS; p++) begin
            frame_buf[p] = (value >= 0) ? pixel_t'(value) : pixel_t'($urandom_range(255, 0));
            in_q.push_back(frame_buf[p]);
        end
        for (int r = 0; r < H; r++) begin
            for (int c = 0; c < W; c++) begin
                exp_q.push_back(pixel_t'(blur_model(r, c)));
            end
        end
    endtask

    // Push queued pixels honouring in_full with optional idle gaps
    task automatic write_pixels(input int gap_max);
        int waited;
        while (in_q.size() > 0) begin
            waited = 0;
            while (in_full) begin
                if (waited >= WAIT_LIMIT) timeout_fail("input FIFO space");
                waited++;
                @(negedge clock);
            end
            in_din = in_q.pop_front();
            in_wr_en = 1'b1;
            @(negedge clock);
            in_wr_en = 1'b0;
            if (gap_max > 0) begin
                repeat ($urandom_range(gap_max, 0)) @(negedge clock);
            end
        end
    endtask

    // Pop and compare output pixels with an optional random stall before each
    task automatic read_pixels(input int count, input int stall_max);
        int waited;
        for (int n = 0; n < count; n++) begin
            if (stall_max > 0) begin
                repeat ($urandom_range(stall_max, 0)) @(negedge clock);
            end
            waited = 0;
            while (out_empty) begin
                if (waited >= WAIT_LIMIT) timeout_fail("output pixel");
                waited++;
                @(negedge clock);
            end
            check_value("out_dout", out_dout, exp_q.pop_front());
            got_q.push_back(out_dout);
            out_rd_en = 1'b1;
            @(negedge clock);
            out_rd_en = 1'b0;
        end
    endtask

    // No extra pixel may follow a frame
    task automatic check_drained();
        repeat (10) @(negedge clock);
        check_value("out_empty", out_empty, 1);
    endtask

    task automatic idle_after_reset();
        check_value("out_empty", out_empty, 1);
        check_value("in_full", in_full, 0);
        repeat (20) begin
            @(negedge clock);
            check_value("out_empty", out_empty, 1);
        end
    endtask

    task automatic constant_frame();
        got_q.delete();
        make_frame(100);
        fork
            write_pixels(0);
            read_pixels(PIXELS, 0);
        join
        // Interior sees the full kernel while corners lose taps
        for (int r = 2; r < H - 2; r++) begin
            for (int c = 2; c < W - 2; c++) begin
                check_value("interior", got_q[r * W + c], 100);
            end
        end
        check_value("corner_darker", got_q[0] < 100, 1);
        check_drained();
    endtask

    task automatic random_frame();
        make_frame(-1);
        fork
            write_pixels(0);
            read_pixels(PIXELS, 0);
        join
        check_drained();
    endtask

    task automatic back_pressure();
        int waited;
        make_frame(-1);
        write_pixels(0);
        // Output FIFO fills and the engine stalls
        waited = 0;
        while (!dut_i.out_full) begin
            if (waited >= WAIT_LIMIT) timeout_fail("output FIFO full");
            waited++;
            @(negedge clock);
        end
        read_pixels(PIXELS, 3);
        check_drained();
    endtask

    task automatic starved_input();
        make_frame(-1);
        fork
            write_pixels(4);
            read_pixels(PIXELS, 0);
        join
        check_drained();
    endtask

    task automatic back_to_back();
        make_frame(-1);
        make_frame(-1);
        fork
            write_pixels(0);
            read_pixels(2 * PIXELS, 1);
        join
        check_drained();
    endtask

    initial begin
        seed_val = 24;
        seed_val = $urandom(seed_val);
        clock = 1'b0;
        reset = 1'b1;
        in_wr_en = 1'b0;
        in_din = '0;
        out_rd_en = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        idle_after_reset();
        constant_frame();
        random_frame();
        back_pressure();
        starved_input();
        back_to_back();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/blur_control.sv
// Blur engine FSM sequencing line fill, filtering, accumulation and output writes
`timescale 1ns/1ps
`default_nettype none

module blur_control
    import blur_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic in_empty,
    input  wire logic out_full,
    input  wire logic fill_done,
    input  wire logic input_done,
    input  wire logic last_pixel,
    output logic      shift,
    output logic      pad,
    output logic      compute,
    output logic      accumulate,
    output logic      in_rd_en,
    output logic      out_wr_en
);

    blur_state_t state;
    blur_state_t next_state;

    // A pixel is ready, or padding zeros are always ready
    logic can_shift;

    assign can_shift = input_done || !in_empty;

    // Shift during fill and on every computed window
    assign shift = ((state == PROLOGUE && !fill_done) || state == FILTER) && can_shift;
    assign pad = input_done;
    // Pop the FIFO only for real pixels
    assign in_rd_en = shift && !input_done;
    assign compute = (state == FILTER) && can_shift;
    assign accumulate = (state == ACCUMULATE);
    // Back-pressure from the output FIFO holds OUTPUT
    assign out_wr_en = (state == OUTPUT) && !out_full;

    always_comb begin
        next_state = state;
        case (state)
            PROLOGUE: begin
                if (fill_done) begin
                    next_state = FILTER;
                end
            end
            FILTER: begin
                if (can_shift) begin
                    next_state = ACCUMULATE;
                end
            end
            ACCUMULATE: begin
                next_state = OUTPUT;
            end
            OUTPUT: begin
                if (!out_full) begin
                    // Back to fill after the frame's last pixel
                    next_state = last_pixel ? PROLOGUE : FILTER;
                end
            end
            default: begin
                next_state = PROLOGUE;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= PROLOGUE;
        end else begin
            state <= next_state;
        end
    end

endmodule

`default_nettype wire

// File: verilog/blur_pkg.sv
// Shared types and the 5x5 Gaussian kernel for the blur engine
`default_nettype none

package blur_pkg;

    // One greyscale sample
    typedef logic [7:0] pixel_t;

    // Engine phases
    // PROLOGUE fills the line buffer until the first centre pixel is in place
    // FILTER forms masked column sums on each shift
    // ACCUMULATE adds the column sums together
    // OUTPUT writes the quotient once the output FIFO has room
    typedef enum logic [1:0] {
        PROLOGUE,
        FILTER,
        ACCUMULATE,
        OUTPUT
    } blur_state_t;

    // Kernel weights, row major, sum is 159
    localparam logic [3:0] blur_kernel [5][5] = '{
        '{4'd2, 4'd4,  4'd5,  4'd4,  4'd2},
        '{4'd4, 4'd9,  4'd12, 4'd9,  4'd4},
        '{4'd5, 4'd12, 4'd15, 4'd12, 4'd5},
        '{4'd4, 4'd9,  4'd12, 4'd9,  4'd4},
        '{4'd2, 4'd4,  4'd5,  4'd4,  4'd2}
    };

endpackage

`default_nettype wire

// File: verilog/blur_position.sv
// Fill, read and centre position counters for the blur engine
`timescale 1ns/1ps
`default_nettype none
`include "blur_cfg.svh"

module blur_position
    import blur_pkg::*;
(
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire logic                              shift,
    input  wire logic                              compute,
    input  wire logic                              out_wr_en,
    output logic                                   fill_done,
    output logic                                   input_done,
    output logic                                   last_pixel,
    output logic [$clog2(`BLUR_HEIGHT)-1:0]        row,
    output logic [$clog2(`BLUR_WIDTH)-1:0]         col
);

    // Shifts needed to bring pixel 0 to the window centre
    localparam int FILL_COUNT = 2 * `BLUR_WIDTH + 3;
    localparam int PIXEL_COUNT = `BLUR_WIDTH * `BLUR_HEIGHT;
    localparam int FILL_W = $clog2(FILL_COUNT + 1);
    localparam int READ_W = $clog2(PIXEL_COUNT + 1);
    localparam int ROW_W = $clog2(`BLUR_HEIGHT);
    localparam int COL_W = $clog2(`BLUR_WIDTH);

    logic [FILL_W-1:0] fill_cnt;
    logic [READ_W-1:0] read_cnt;
    logic              frame_end;

    assign fill_done = (fill_cnt == FILL_W'(FILL_COUNT));
    // All pixels of the frame have left the input FIFO
    assign input_done = (read_cnt == READ_W'(PIXEL_COUNT));
    // Final pixel written, start over for the next frame
    assign frame_end = out_wr_en && last_pixel;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            fill_cnt <= '0;
            read_cnt <= '0;
            row <= '0;
            col <= '0;
            last_pixel <= 1'b0;
        end else if (frame_end) begin
            fill_cnt <= '0;
            read_cnt <= '0;
            row <= '0;
            col <= '0;
            last_pixel <= 1'b0;
        end else begin
            if (shift && !fill_done) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            if (shift && !input_done) begin
                read_cnt <= read_cnt + 1'b1;
            end
            // Centre moves one pixel per computed window
            if (compute) begin
                if (col == COL_W'(`BLUR_WIDTH - 1)) begin
                    col <= '0;
                    row <= row + 1'b1;
                    // Bottom right corner just went into the sums
                    if (row == ROW_W'(`BLUR_HEIGHT - 1)) begin
                        last_pixel <= 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/blur_top.sv
// Gaussian blur top level with input FIFO, blur engine and output FIFO
`timescale 1ns/1ps
`default_nettype none
`include "blur_cfg.svh"

module blur_top
    import blur_pkg::*;
(
    input  wire logic   clock,
    input  wire logic   reset,
    input  wire logic   in_wr_en,
    input  wire pixel_t in_din,
    output logic        in_full,
    input  wire logic   out_rd_en,
    output logic        out_empty,
    output pixel_t      out_dout
);

    // Input FIFO read side
    logic   in_empty;
    logic   in_rd_en;
    pixel_t in_dout;

    // Output FIFO write side
    logic   out_full;
    logic   out_wr_en;
    pixel_t out_din;

    // Engine strobes and position
    logic                              shift;
    logic                              pad;
    logic                              compute;
    logic                              accumulate;
    logic                              fill_done;
    logic                              input_done;
    logic                              last_pixel;
    logic [$clog2(`BLUR_HEIGHT)-1:0]   row;
    logic [$clog2(`BLUR_WIDTH)-1:0]    col;

    pixel_fifo in_fifo_i (
        .clock(clock),
        .reset(reset),
        .wr_en(in_wr_en),
        .din(in_din),
        .full(in_full),
        .rd_en(in_rd_en),
        .empty(in_empty),
        .dout(in_dout)
    );

    blur_control blur_control_i (
        .clock(clock),
        .reset(reset),
        .in_empty(in_empty),
        .out_full(out_full),
        .fill_done(fill_done),
        .input_done(input_done),
        .last_pixel(last_pixel),
        .shift(shift),
        .pad(pad),
        .compute(compute),
        .accumulate(accumulate),
        .in_rd_en(in_rd_en),
        .out_wr_en(out_wr_en)
    );

    blur_position blur_position_i (
        .clock(clock),
        .reset(reset),
        .shift(shift),
        .compute(compute),
        .out_wr_en(out_wr_en),
        .fill_done(fill_done),
        .input_done(input_done),
        .last_pixel(last_pixel),
        .row(row),
        .col(col)
    );

    blur_window blur_window_i (
        .clock(clock),
        .reset(reset),
        .shift(shift),
        .pad(pad),
        .pixel_in(in_dout),
        .compute(compute),
        .accumulate(accumulate),
        .row(row),
        .col(col),
        .out_din(out_din)
    );

    pixel_fifo out_fifo_i (
        .clock(clock),
        .reset(reset),
        .wr_en(out_wr_en),
        .din(out_din),
        .full(out_full),
        .rd_en(out_rd_en),
        .empty(out_empty),
        .dout(out_dout)
    );

endmodule

`default_nettype wire

// File: verilog/blur_window.sv
// Line buffer and masked 5x5 Gaussian multiply-accumulate with fixed divisor
`timescale 1ns/1ps
`default_nettype none
`include "blur_cfg.svh"

module blur_window
    import blur_pkg::*;
(
    input  wire logic                              clock,
    input  wire logic                              reset,
    input  wire logic                              shift,
    input  wire logic                              pad,
    input  wire pixel_t                            pixel_in,
    input  wire logic                              compute,
    input  wire logic                              accumulate,
    input  wire logic [$clog2(`BLUR_HEIGHT)-1:0]   row,
    input  wire logic [$clog2(`BLUR_WIDTH)-1:0]    col,
    output pixel_t                                 out_din
);

    // Four full lines plus five pixels cover the 5x5 window
    localparam int SHIFT_LEN = 4 * `BLUR_WIDTH + 5;
    // Worst case total is 255 * 159, fits 16 bits
    localparam int SUM_W = 16;

    // Index 0 holds the oldest pixel, centre sits at 2*W+2
    pixel_t [0:SHIFT_LEN-1] shift_reg;
    pixel_t                 new_pixel;

    // One partial sum per kernel column
    logic [SUM_W-1:0] col_sum_c [5];
    logic [SUM_W-1:0] col_sum [5];
    logic [SUM_W-1:0] total_c;
    logic [SUM_W-1:0] total;

    // Zeros fill the buffer once the frame is fully read
    assign new_pixel = pad ? pixel_t'(0) : pixel_in;

    always_ff @(posedge clock) begin
        if (shift) begin
            shift_reg <= {shift_reg[1:SHIFT_LEN-1], new_pixel};
        end
    end

    // Masked MAC over the window as it stands before the shift
    always_comb begin
        int tap_row;
        int tap_col;
        for (int j = 0; j < 5; j++) begin
            col_sum_c[j] = '0;
        end
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                tap_row = int'(row) + i - 2;
                tap_col = int'(col) + j - 2;
                // Skip taps past any image edge
                if (tap_row >= 0 && tap_row < `BLUR_HEIGHT &&
                    tap_col >= 0 && tap_col < `BLUR_WIDTH) begin
                    col_sum_c[j] = col_sum_c[j] +
                        SUM_W'(shift_reg[i * `BLUR_WIDTH + j]) *
                        SUM_W'(blur_kernel[i][j]);
                end
            end
        end
    end

    // Adder tree over the registered column sums
    always_comb begin
        total_c = '0;
        for (int j = 0; j < 5; j++) begin
            total_c = total_c + col_sum[j];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int j = 0; j < 5; j++) begin
                col_sum[j] <= '0;
            end
            total <= '0;
        end else begin
            if (compute) begin
                col_sum <= col_sum_c;
            end
            if (accumulate) begin
                total <= total_c;
            end
        end
    end

    // Fixed denominator, quotient never exceeds 255
    assign out_din = pixel_t'(total / `BLUR_DIVISOR);

endmodule

`default_nettype wire

// File: verilog/pixel_fifo.sv
// Show-ahead synchronous pixel FIFO with wrap-bit pointers
`timescale 1ns/1ps
`default_nettype none
`include "blur_cfg.svh"

module pixel_fifo
    import blur_pkg::*;
(
    input  wire logic   clock,
    input  wire logic   reset,
    input  wire logic   wr_en,
    input  wire pixel_t din,
    output logic        full,
    input  wire logic   rd_en,
    output logic        empty,
    output pixel_t      dout
);

    localparam int DEPTH = `BLUR_FIFO_DEPTH;
    localparam int ADDR_W = $clog2(DEPTH);

    // Circular pixel storage
    pixel_t mem [DEPTH];

    // Pointers with one extra bit to tell full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;

    logic do_write;
    logic do_read;

    // Same address, different lap means full
    assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                  (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    // Ignore writes when full and reads when empty
    assign do_write = wr_en && !full;
    assign do_read = rd_en && !empty;

    // Head entry shown without a read strobe
    assign dout = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr[ADDR_W-1:0]] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
